/* hw/mag_fifo.sv */
`include "peak_consts.svh"

module mag_fifo (
  input  logic          clk,
  input  logic          i_rst,
  input  logic          i_clear,

  mag_stream_if.sink    s_in,
  mag_stream_if.source  m_out
);

  localparam int ENTRY_W = $bits(peak_pkg::mag_t) + 2;
  localparam int ADDR_W  = $clog2(`PK_FIFO_DEPTH);

  logic [ENTRY_W-1:0] mem [`PK_FIFO_DEPTH];
  logic [ADDR_W:0]    wr_ptr;  // Extra top bit tells full from empty
  logic [ADDR_W:0]    rd_ptr;
  logic [ENTRY_W-1:0] wr_word;
  logic [ENTRY_W-1:0] rd_word;
  logic               mem_empty;
  logic               mem_full;
  logic               wr_en;
  logic               load_out;
  logic               bypass;
  logic               mem_wr;
  logic               mem_rd;

  assign wr_word = {s_in.flag, s_in.tlast, s_in.tdata};
  assign rd_word = mem[rd_ptr[ADDR_W-1:0]];

  assign mem_empty = (wr_ptr == rd_ptr);
  assign mem_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign s_in.tready = ~mem_full;
  assign wr_en       = s_in.tvalid & ~mem_full;

  ////////////////////
  // Buffer control
  ////////////////////

  assign load_out = ~m_out.tvalid | m_out.tready;
  assign bypass   = load_out & mem_empty;  // Beat skips the buffer and lands in the output

  assign mem_wr = wr_en & ~bypass;
  assign mem_rd = load_out & ~mem_empty;

  always_ff @(posedge clk) begin
    if (mem_wr) begin
      mem[wr_ptr[ADDR_W-1:0]] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst | i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
      if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_rst | i_clear) begin
      m_out.tvalid <= 1'b0;
    end else if (load_out) begin
      m_out.tvalid <= ~mem_empty | wr_en;
    end
  end

  // Older entries in the buffer always go out before the incoming beat
  always_ff @(posedge clk) begin
    if (mem_rd) begin
      {m_out.flag, m_out.tlast, m_out.tdata} <= rd_word;
    end else if (bypass & wr_en) begin
      {m_out.flag, m_out.tlast, m_out.tdata} <= wr_word;
    end
  end

endmodule

/* hw/mag_stream_if.sv */
interface mag_stream_if;

  logic            tvalid;
  logic            tready;
  logic            tlast;
  peak_pkg::mag_t  tdata;
  logic            flag;  // Magnitude reached the threshold

  modport source (
    output tvalid,
    output tlast,
    output tdata,
    output flag,
    input  tready
  );

  modport sink (
    input  tvalid,
    input  tlast,
    input  tdata,
    input  flag,
    output tready
  );

endinterface

/* hw/mag_threshold.sv */
module mag_threshold (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_clear,

  input  logic                i_valid,
  output logic                o_ready,
  input  logic                i_last,
  input  peak_pkg::iq_t       i_i,
  input  peak_pkg::iq_t       i_q,

  input  peak_pkg::mag_t      i_threshold,

  mag_stream_if.source        m_out
);

  peak_pkg::mag_t abs_i;
  peak_pkg::mag_t abs_q;
  peak_pkg::mag_t mag_max;
  peak_pkg::mag_t mag_min;
  peak_pkg::mag_t mag_est;
  logic           accept;

  ////////////////////
  // Magnitude estimate
  ////////////////////

  // The most negative input maps onto the top bit of the unsigned result
  assign abs_i = (i_i < 0) ? peak_pkg::mag_t'(-i_i) : peak_pkg::mag_t'(i_i);
  assign abs_q = (i_q < 0) ? peak_pkg::mag_t'(-i_q) : peak_pkg::mag_t'(i_q);

  assign mag_max = (abs_i >= abs_q) ? abs_i : abs_q;
  assign mag_min = (abs_i >= abs_q) ? abs_q : abs_i;

  assign mag_est = mag_max + (mag_min >> 1);  // Tops out at 3/4 of full range so it cannot overflow

  ////////////////////
  // Output stage
  ////////////////////

  assign o_ready = ~m_out.tvalid | m_out.tready;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (i_rst | i_clear) begin
      m_out.tvalid <= 1'b0;
    end else if (o_ready) begin
      m_out.tvalid <= i_valid;
    end
  end

  // Payload only moves on an accepted sample, so it holds during a stall
  always_ff @(posedge clk) begin
    if (accept) begin
      m_out.tdata <= mag_est;
      m_out.flag  <= (mag_est >= i_threshold);
      m_out.tlast <= i_last;
    end
  end

endmodule

/* hw/peak_consts.svh */
`ifndef PEAK_CONSTS_SVH
`define PEAK_CONSTS_SVH

// Sample and magnitude widths
`define PK_IQ_W        16
`define PK_MAG_W       16
`define PK_NRX_W       16

// Peak decision
`define PK_NRX_TRIG    64
`define PK_HIST_W      8

`define PK_FIFO_DEPTH  16  // Must stay a power of two

`endif

/* hw/peak_detect.sv */
`include "peak_consts.svh"

module peak_detect (
  input  logic            clk,
  input  logic            i_rst,
  input  logic            i_clear,

  mag_stream_if.sink      s_in,

  output logic            o_valid,
  input  logic            i_ready,
  output logic            o_last,

  output logic            o_peak_stb,
  output peak_pkg::nrx_t  o_nrx_after_peak
);

  typedef enum logic [1:0] {
    st_init,
    st_max,
    st_trig,
    st_wait
  } state_t;

  state_t                 state;
  peak_pkg::mag_t         max_mag;
  peak_pkg::nrx_t         nrx_trig;  // Flagged beats after the first one of the run
  logic [`PK_HIST_W-1:0]  hist;
  logic                   beat;

  assign s_in.tready = ~o_valid | i_ready;
  assign beat        = s_in.tvalid & s_in.tready;

  ////////////////////
  // Output stage
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_rst | i_clear) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else if (s_in.tready) begin
      o_valid <= s_in.tvalid;
      o_last  <= s_in.tvalid & s_in.tlast;
    end
  end

  ////////////////////
  // Peak FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_rst | i_clear) begin
      state            <= st_init;
      nrx_trig         <= '0;
      hist             <= '0;
      o_peak_stb       <= 1'b0;
      o_nrx_after_peak <= '0;
    end else if (beat) begin
      case (state)
        st_init: begin
          // Every beat here may open a run
          max_mag          <= s_in.tdata;
          nrx_trig         <= '0;
          hist             <= '0;
          o_peak_stb       <= 1'b0;
          o_nrx_after_peak <= '0;
          if (s_in.flag) state <= st_max;
        end
        st_max: begin
          if (s_in.flag) begin
            nrx_trig <= nrx_trig + 1'b1;
            if (s_in.tdata > max_mag) begin
              max_mag          <= s_in.tdata;
              o_nrx_after_peak <= '0;
              hist             <= {hist[`PK_HIST_W-2:0], 1'b1};  // One more rise
            end else begin
              o_nrx_after_peak <= o_nrx_after_peak + 1'b1;
            end
          end else begin
            o_nrx_after_peak <= o_nrx_after_peak + 1'b1;
            state            <= st_trig;
          end
        end
        st_trig: begin
          // Run must be long enough and have kept rising
          if ((nrx_trig >= `PK_NRX_TRIG) && (&hist)) begin
            o_peak_stb <= 1'b1;
            state      <= st_wait;
          end else begin
            state <= st_init;
          end
        end
        st_wait: begin
          state <= st_init;
        end
        default: state <= st_init;
      endcase
    end
  end

endmodule

/* hw/peak_pkg.sv */
`include "peak_consts.svh"

package peak_pkg;

  ////////////////////
  // Sample types
  ////////////////////

  // One signed I or Q component from the front end
  typedef logic signed [`PK_IQ_W-1:0] iq_t;

  typedef logic [`PK_MAG_W-1:0] mag_t;  // Max plus half min estimate

  ////////////////////
  // Counter types
  ////////////////////

  typedef logic [`PK_NRX_W-1:0] nrx_t;

endpackage

/* hw/preamble_peak_top.sv */
module preamble_peak_top (
  input  logic            clk,
  input  logic            i_rst,
  input  logic            i_clear,

  input  peak_pkg::mag_t  i_threshold,

  // IQ sample stream
  input  logic            i_valid,
  output logic            o_ready,
  input  logic            i_last,
  input  peak_pkg::iq_t   i_i,
  input  peak_pkg::iq_t   i_q,

  // Detector stream without data
  output logic            o_valid,
  input  logic            i_ready,
  output logic            o_last,

  output logic            o_peak_stb,
  output peak_pkg::nrx_t  o_nrx_after_peak
);

  mag_stream_if s_mag ();  // Producer to buffer
  mag_stream_if s_buf ();  // Buffer to detector

  mag_threshold i_mag_threshold (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_last      (i_last),
    .i_i         (i_i),
    .i_q         (i_q),
    .i_threshold (i_threshold),
    .m_out       (s_mag.source)
  );

  mag_fifo i_mag_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .s_in    (s_mag.sink),
    .m_out   (s_buf.source)
  );

  peak_detect i_peak_detect (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_clear          (i_clear),
    .s_in             (s_buf.sink),
    .o_valid          (o_valid),
    .i_ready          (i_ready),
    .o_last           (o_last),
    .o_peak_stb       (o_peak_stb),
    .o_nrx_after_peak (o_nrx_after_peak)
  );

endmodule

/* preamble_peak_top.f */
+incdir+hw
hw/peak_pkg.sv
hw/mag_stream_if.sv
hw/mag_threshold.sv
hw/mag_fifo.sv
hw/peak_detect.sv
hw/preamble_peak_top.sv
tb/tb_preamble_peak.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f preamble_peak_top.f \
  --top-module tb_preamble_peak \
  -Mdir obj_dir

output=$(./obj_dir/Vtb_preamble_peak)
echo "$output"

if echo "$output" | grep -qxF "Finished with no errors"; then
  exit 0
else
  exit 1
fi

/* tb/tb_preamble_peak.sv */
`include "peak_consts.svh"

module tb_preamble_peak;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 7;
  localparam int MAXS  = 128;
  localparam int PAD   = 6;  // Unflagged samples on each side of a run

  typedef struct packed {
    int thr;
    int n;        // Run length
    int rises;    // Strict rises after the first run sample
    int p;        // Index of the run maximum
    int clr;
    int bp;       // Random i_ready
    int mix_pos;  // Sample that also carries a nonzero Q
    int mix_q;
    int exp_stb;
    int exp_cnt;  // N - p at the strobe
  } row_t;

  logic                 clk = 1'b0;
  logic                 i_rst;
  logic                 i_clear;
  peak_pkg::mag_t       i_threshold;
  logic                 i_valid;
  logic                 o_ready;
  logic                 i_last;
  peak_pkg::iq_t        i_i;
  peak_pkg::iq_t        i_q;
  logic                 o_valid;
  logic                 i_ready;
  logic                 o_last;
  logic                 o_peak_stb;
  peak_pkg::nrx_t       o_nrx_after_peak;

  row_t   rows [NROWS];
  int     smp_i [MAXS];
  int     smp_q [MAXS];
  int     mags [MAXS];
  int     nsamp = 0;
  int     row_start = 0;
  int     beats_base = 0;
  int     stb_base = 0;
  int     in_beats = 0;
  int     out_beats = 0;
  int     stb_rises = 0;
  int     stb_cnt = 0;
  int     mon_errors = 0;
  int     errors = 0;
  int     cycles = 0;
  int     limit = 0;
  logic   stb_prev = 1'b0;
  logic   bp_on = 1'b0;
  integer seed = 25;

  preamble_peak_top i_preamble_peak_top (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_clear          (i_clear),
    .i_threshold      (i_threshold),
    .i_valid          (i_valid),
    .o_ready          (o_ready),
    .i_last           (i_last),
    .i_i              (i_i),
    .i_q              (i_q),
    .o_valid          (o_valid),
    .i_ready          (i_ready),
    .o_last           (o_last),
    .o_peak_stb       (o_peak_stb),
    .o_nrx_after_peak (o_nrx_after_peak)
  );

  always #4 clk = ~clk;

  ////////////////////
  // Stimulus and model
  ////////////////////

  // Larger absolute value plus half the smaller one rounded down
  function automatic int est_mag(input int i, input int q);
    int ai;
    int aq;
    ai = (i < 0) ? -i : i;
    aq = (q < 0) ? -q : q;
    if (ai >= aq) return ai + aq / 2;
    return aq + ai / 2;
  endfunction

  function automatic int run_target(input int r, input int k);
    int ups;
    int j;
    ups = 0;
    if (k > rows[r].p) return rows[r].thr;  // Past the peak the run sits at the threshold
    for (j = 1; j <= rows[r].rises; j++) begin
      if ((j * rows[r].p) / rows[r].rises <= k) ups++;
    end
    return rows[r].thr + 4 * ups;
  endfunction

  task automatic build_row(input int r);
    int m;
    int k;
    int s;
    nsamp = rows[r].n + 2 * PAD;
    for (s = 0; s < nsamp; s++) begin
      k = s - PAD;
      m = (k >= 0 && k < rows[r].n) ? run_target(r, k) : rows[r].thr - 1;
      if (s == rows[r].mix_pos) begin
        smp_q[s] = rows[r].mix_q;
        smp_i[s] = -(m - rows[r].mix_q / 2);  // Estimate lands on m
      end else begin
        smp_q[s] = 0;
        smp_i[s] = (s % 2 == 1) ? -m : m;
      end
      mags[s] = est_mag(smp_i[s], smp_q[s]);
    end
  endtask

  task automatic run_model(input int thr, input int start, output int n_rise, output int cnt_at);
    int state;  // 0 INIT, 1 MAX, 2 TRIG, 3 WAIT
    int mx;
    int aft;
    int trig;
    int ups;
    int s;
    state = 0;
    mx = 0;
    aft = 0;
    trig = 0;
    ups = 0;
    n_rise = 0;
    cnt_at = 0;
    for (s = start; s < nsamp; s++) begin
      case (state)
        0: begin
          mx = mags[s];
          aft = 0;
          trig = 0;
          ups = 0;
          if (mags[s] >= thr) state = 1;
        end
        1: begin
          if (mags[s] < thr) begin
            aft++;
            state = 2;
          end else begin
            trig++;
            if (mags[s] > mx) begin
              mx = mags[s];
              aft = 0;
              ups++;
            end else begin
              aft++;
            end
          end
        end
        2: begin
          // History is all ones once it has seen as many rises as it is long
          if (trig >= `PK_NRX_TRIG && ups >= `PK_HIST_W) begin
            n_rise++;
            cnt_at = aft;
            state = 3;
          end else begin
            state = 0;
          end
        end
        default: state = 0;
      endcase
    end
  endtask

  task automatic step();
    int rnd;
    @(negedge clk);
    rnd = $random(seed);
    i_ready = bp_on ? rnd[0] : 1'b1;
  endtask

  task automatic send_sample(input int s);
    i_valid = 1'b1;
    i_i = peak_pkg::iq_t'(smp_i[s]);
    i_q = peak_pkg::iq_t'(smp_q[s]);
    i_last = (s == nsamp - 1);
    while (!o_ready) step();
    step();  // The beat moves on the rising edge in here
    in_beats++;
  endtask

  task automatic pulse_clear(input int s);
    i_valid = 1'b0;
    i_clear = 1'b1;
    step();
    i_clear = 1'b0;
    assert (!o_valid && !o_peak_stb && o_ready) else begin
      errors++;
      $display("ERROR at %0d ns: o_valid %0b, o_peak_stb %0b, o_ready %0b after i_clear",
               $time, o_valid, o_peak_stb, o_ready);
    end
    beats_base = out_beats;
    stb_base = stb_rises;
    row_start = s;
    in_beats = 0;
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  always @(posedge clk) begin
    if (o_valid && i_ready) begin
      assert (o_last == (out_beats - beats_base + row_start == nsamp - 1)) else begin
        mon_errors++;
        $display("ERROR at %0d ns: o_last is %0b on output beat %0d",
                 $time, o_last, out_beats - beats_base);
      end
      out_beats++;
    end
    if (o_peak_stb && !stb_prev) begin
      stb_rises++;
      stb_cnt = int'(o_nrx_after_peak);
    end
    stb_prev = o_peak_stb;
  end

  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not end within %0d clock cycles", limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int m_rises;
    int m_cnt;
    int row_rises;
    int row_beats;
    int errs_before;
    int total;
    int pass_rows;
    int fail_rows;
    int r;
    int s;
    i_rst = 1'b1;
    i_clear = 1'b0;
    i_threshold = '0;
    i_valid = 1'b0;
    i_last = 1'b0;
    i_i = '0;
    i_q = '0;
    i_ready = 1'b1;

    //        thr   n  rise  p clr bp mix  q  stb cnt
    rows[0] = '{1000, 80, 10, 40, 0, 0, 76, 200, 1, 40};
    rows[1] = '{1000, 40, 10, 20, 0, 0,  3, 300, 0,  0};  // Too short
    rows[2] = '{1000, 80,  5, 40, 0, 0, 56,  61, 0,  0};  // Too few rises
    rows[3] = '{ 500, 70,  9, 30, 0, 0, 76, 100, 1, 40};
    rows[4] = '{1000, 80, 10, 40, 0, 1, 80,  40, 1, 40};
    rows[5] = '{1000, 80, 10, 40, 1, 0, 60,   2, 0,  0};
    rows[6] = '{1000, 80, 10, 40, 0, 0, 81, 500, 1, 40};

    total = 0;
    for (r = 0; r < NROWS; r++) total += rows[r].n + 2 * PAD;
    limit = 20 * total + 200;

    repeat (16) step();
    i_rst = 1'b0;
    step();
    assert (o_ready && !o_valid && !o_last && !o_peak_stb) else begin
      errors++;
      $display("ERROR at %0d ns: after reset o_ready %0b o_valid %0b o_last %0b o_peak_stb %0b",
               $time, o_ready, o_valid, o_last, o_peak_stb);
    end

    pass_rows = 0;
    fail_rows = 0;
    for (r = 0; r < NROWS; r++) begin
      errs_before = errors + mon_errors;
      bp_on = (rows[r].bp != 0);
      i_threshold = peak_pkg::mag_t'(rows[r].thr);
      build_row(r);
      row_start = 0;
      beats_base = out_beats;
      stb_base = stb_rises;
      in_beats = 0;
      for (s = 0; s < nsamp; s++) begin
        if (rows[r].clr != 0 && s == PAD + rows[r].n / 2) pulse_clear(s);
        send_sample(s);
      end
      i_valid = 1'b0;
      i_last = 1'b0;
      while (out_beats - beats_base < in_beats) step();
      repeat (4) step();  // A repeated beat would show up here
      row_beats = out_beats - beats_base;
      row_rises = stb_rises - stb_base;
      run_model(rows[r].thr, row_start, m_rises, m_cnt);

      assert (m_rises == rows[r].exp_stb && (m_rises == 0 || m_cnt == rows[r].exp_cnt)) else begin
        errors++;
        $display("Row %0d: the table entry does not match the peak rule for its samples", r);
      end
      assert (row_beats == in_beats) else begin
        errors++;
        $display("ERROR at %0d ns: row %0d gave %0d output beats for %0d input beats",
                 $time, r, row_beats, in_beats);
      end
      assert (row_rises > 0 || m_rises == 0) else begin
        errors++;
        $display("Row %0d: the peak strobe never rose although this run should raise it", r);
      end
      assert (row_rises == m_rises || row_rises == 0) else begin
        errors++;
        $display("ERROR at %0d ns: row %0d strobe rose %0d times, expected %0d",
                 $time, r, row_rises, m_rises);
      end
      if (row_rises > 0 && m_rises > 0) begin
        assert (stb_cnt == m_cnt) else begin
          errors++;
          $display("ERROR at %0d ns: row %0d o_nrx_after_peak %0d at the strobe, expected %0d",
                   $time, r, stb_cnt, m_cnt);
        end
      end

      if (errors + mon_errors == errs_before) pass_rows++;
      else fail_rows++;
      $display("Row %0d %s: %0d of %0d beats out, strobe rises %0d, count %0d", r,
               (errors + mon_errors == errs_before) ? "passed" : "failed",
               row_beats, in_beats, row_rises, stb_cnt);
    end

    $display("Rows passed: %0d, rows failed: %0d", pass_rows, fail_rows);
    if (errors + mon_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
